// File: design/rename_pkg.sv
/*
 * Architectural constants for the rename subsystem, the register index
 * and physical tag types, and the map-table write bundle.
 */

package rename_pkg;

	// Number of architectural registers visible to software.
	localparam int arch_count = 32;

	// Rename and retire width in instructions per cycle.
	localparam int slot_count = 2;

	// Width of an architectural register index.
	localparam int arch_width = $clog2(arch_count);

	// Width of a physical tag, wide enough for 96 physical registers.
	localparam int tag_width = 7;

	// Architectural register index, r0 to r31.
	typedef logic [arch_width-1:0] arch_reg;

	// Physical register tag.
	typedef logic [tag_width-1:0] phys_tag;

	// One write into a register map.
	// The enable qualifies the whole entry, so arch and tag are only
	// meaningful while it is high.
	typedef struct packed {
		logic    enable;
		arch_reg arch;
		phys_tag tag;
	} map_write;

endpackage

// File: design/pipe_pkg.sv
/*
 * Bundles passed between the rename and retire stages: the destination
 * kind, the rename input and result groups, and the retire group.
 */

package pipe_pkg;

	// Whether an instruction writes a destination register.
	typedef enum logic {
		dest_none = 1'b0,
		dest_reg  = 1'b1
	} dest_kind;

	// One instruction entering rename (16 bits).
	typedef struct packed {
		rename_pkg::arch_reg src0;
		rename_pkg::arch_reg src1;
		rename_pkg::arch_reg dest;
		dest_kind            kind;
	} rename_in;

	// Up to two instructions in program order, slot 0 being the older (32 bits).
	typedef rename_in [1:0] rename_group;

	// One renamed instruction (34 bits).
	// For a dest_none slot both new_tag and old_tag are zero.
	typedef struct packed {
		rename_pkg::phys_tag src0_tag;
		rename_pkg::phys_tag src1_tag;
		rename_pkg::phys_tag new_tag;
		rename_pkg::phys_tag old_tag;
		rename_pkg::arch_reg dest;
		dest_kind            kind;
	} rename_out;

	// Result for a whole group (68 bits).
	typedef rename_out [1:0] rename_result;

	// One instruction leaving the reorder buffer (20 bits).
	typedef struct packed {
		rename_pkg::arch_reg dest;
		rename_pkg::phys_tag new_tag;
		rename_pkg::phys_tag old_tag;
		dest_kind            kind;
	} retire_entry;

	// Retiring instructions, slot 0 the oldest (42 bits).
	// Only the first count slots are valid, count being 0, 1 or 2.
	typedef struct packed {
		retire_entry [1:0] slots;
		logic [1:0]        count;
	} retire_group;

endpackage

// File: design/free_list.sv
/*
 * Circular FIFO of free physical tags with two allocate ports, two
 * release ports, an available count and full-flush recovery.
 */

`timescale 1ns/1ns

module free_list #(
	parameter int phys_count = 96
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic [1:0]                alloc_count,
	output rename_pkg::phys_tag [1:0] alloc_tags,
	input  logic [1:0]                release_count,
	input  rename_pkg::phys_tag [1:0] release_tags,
	input  logic                      recover,
	output logic [6:0]                available
);

	import rename_pkg::*;

	// Every physical register that is not mapped at reset lives here.
	localparam int depth = phys_count - arch_count;
	localparam int ptr_width = $clog2(depth);

	// Tags between tail and head, going forward, are free.
	// Tags from head round to tail belong to instructions not yet retired.
	phys_tag slots [depth];
	logic [ptr_width-1:0] head;
	logic [ptr_width-1:0] tail;
	logic [ptr_width-1:0] head_one;
	logic [ptr_width-1:0] head_next;
	logic [ptr_width-1:0] tail_one;
	logic [ptr_width-1:0] tail_next;

	// Steps a pointer forward with wrap at the list depth.
	// The depth need not be a power of two.
	function automatic logic [ptr_width-1:0] advance(
		input logic [ptr_width-1:0] ptr,
		input logic [1:0]           step
	);
		int sum;
		sum = int'(ptr) + int'(step);
		if (sum >= depth) begin
			sum = sum - depth;
		end
		return ptr_width'(sum);
	endfunction

	assign head_one = advance(head, 2'd1);
	assign head_next = advance(head, release_count);
	assign tail_one = advance(tail, 2'd1);
	assign tail_next = advance(tail, alloc_count);

	// The two oldest free tags, offered to rename every cycle.
	// The rename stage decides how many it really takes.
	assign alloc_tags[0] = slots[tail];
	assign alloc_tags[1] = slots[tail_one];

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			available <= 7'(depth);
			// The list starts full with 32, 33 and on up to 95.
			for (int i = 0; i < depth; i++) begin
				slots[i] <= phys_tag'(arch_count + i);
			end
		end else begin
			// Released tags join the young end, slot 0 first.
			if (release_count != 2'd0) begin
				slots[head] <= release_tags[0];
			end
			if (release_count == 2'd2) begin
				slots[head_one] <= release_tags[1];
			end
			head <= head_next;

			// Recover happens after this cycle's releases.
			// Everything from the new head round to the old tail was handed
			// to instructions that are now discarded, so the whole ring is
			// free again.
			if (recover) begin
				tail <= head_next;
				available <= 7'(depth);
			end else begin
				tail <= tail_next;
				available <= available + 7'(release_count) - 7'(alloc_count);
			end
		end
	end

endmodule

// File: design/map_table.sv
/*
 * Speculative and architectural register maps with combinational reads,
 * slot-ordered writes and recovery of the speculative map.
 */

`timescale 1ns/1ns

module map_table (
	input  logic                       clock,
	input  logic                       reset,
	input  rename_pkg::arch_reg [3:0]  read_regs,
	output rename_pkg::phys_tag [3:0]  read_tags,
	input  rename_pkg::arch_reg [1:0]  dest_regs,
	output rename_pkg::phys_tag [1:0]  old_tags,
	input  rename_pkg::map_write [1:0] spec_writes,
	input  rename_pkg::map_write [1:0] arch_writes,
	input  logic                       recover
);

	import rename_pkg::*;

	// The speculative map follows rename.
	// The architectural map follows retire.
	phys_tag spec_map [arch_count];
	phys_tag arch_map [arch_count];

	// Architectural map as it will be after this cycle's retires.
	phys_tag arch_next [arch_count];

	// Source reads and destination reads both see the speculative map.
	// Writes from the same cycle are not visible here, the rename stage
	// handles those with its own bypass.
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			read_tags[i] = spec_map[read_regs[i]];
		end
		for (int i = 0; i < slot_count; i++) begin
			old_tags[i] = spec_map[dest_regs[i]];
		end
	end

	// Slot 1 is younger, so its write lands last when both name one register.
	always_comb begin
		arch_next = arch_map;
		for (int s = 0; s < slot_count; s++) begin
			if (arch_writes[s].enable) begin
				arch_next[arch_writes[s].arch] = arch_writes[s].tag;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// Identity mapping, register r holds tag r.
			for (int i = 0; i < arch_count; i++) begin
				spec_map[i] <= phys_tag'(i);
				arch_map[i] <= phys_tag'(i);
			end
		end else begin
			arch_map <= arch_next;
			if (recover) begin
				// Retires of this cycle are included in the copy.
				spec_map <= arch_next;
			end else begin
				// Later slots overwrite earlier ones.
				for (int s = 0; s < slot_count; s++) begin
					if (spec_writes[s].enable) begin
						spec_map[spec_writes[s].arch] <= spec_writes[s].tag;
					end
				end
			end
		end
	end

endmodule

// File: design/rename_stage.sv
/*
 * Two-wide rename: map reads, intra-group bypass, tag allocation,
 * input ready and the registered result group.
 */

`timescale 1ns/1ns

module rename_stage (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       rename_valid,
	input  pipe_pkg::rename_group      rename_group,
	output logic                       rename_ready,
	input  logic                       flush_pending,
	input  logic [6:0]                 available,
	input  rename_pkg::phys_tag [1:0]  alloc_tags,
	output logic [1:0]                 alloc_count,
	output rename_pkg::arch_reg [3:0]  read_regs,
	input  rename_pkg::phys_tag [3:0]  read_tags,
	output rename_pkg::arch_reg [1:0]  dest_regs,
	input  rename_pkg::phys_tag [1:0]  old_tags,
	output rename_pkg::map_write [1:0] spec_writes,
	output logic                       result_valid,
	output pipe_pkg::rename_result     rename_result
);

	import rename_pkg::*;
	import pipe_pkg::*;

	logic                   fire;
	logic [1:0]             has_dest;
	logic                   src0_hit;
	logic                   src1_hit;
	logic                   dest_hit;
	phys_tag [1:0]          new_tags;
	pipe_pkg::rename_result next_result;

	// Two free tags must be on hand whatever the group holds.
	// A pending flush also blocks, since its map copy would lose the writes.
	assign rename_ready = (available >= 7'd2) && !flush_pending;
	assign fire = rename_valid && rename_ready;

	assign has_dest[0] = rename_group[0].kind == dest_reg;
	assign has_dest[1] = rename_group[1].kind == dest_reg;

	// Read ports 0 and 1 serve slot 0, ports 2 and 3 serve slot 1.
	assign read_regs[0] = rename_group[0].src0;
	assign read_regs[1] = rename_group[0].src1;
	assign read_regs[2] = rename_group[1].src0;
	assign read_regs[3] = rename_group[1].src1;
	assign dest_regs[0] = rename_group[0].dest;
	assign dest_regs[1] = rename_group[1].dest;

	// Slot 1 depends on slot 0 only when slot 0 really writes.
	assign src0_hit = has_dest[0] && (rename_group[1].src0 == rename_group[0].dest);
	assign src1_hit = has_dest[0] && (rename_group[1].src1 == rename_group[0].dest);
	assign dest_hit = has_dest[0] && (rename_group[1].dest == rename_group[0].dest);

	// Tags are handed out oldest first.
	// Slot 1 takes the second tag only if slot 0 used the first one.
	always_comb begin
		new_tags[0] = has_dest[0] ? alloc_tags[0] : '0;
		if (!has_dest[1]) begin
			new_tags[1] = '0;
		end else if (has_dest[0]) begin
			new_tags[1] = alloc_tags[1];
		end else begin
			new_tags[1] = alloc_tags[0];
		end
	end

	assign alloc_count = fire ? {1'b0, has_dest[0]} + {1'b0, has_dest[1]} : 2'd0;

	// Slot 0 reads the map directly.
	// Slot 1 sees slot 0's new tag where the registers collide.
	always_comb begin
		next_result[0].src0_tag = read_tags[0];
		next_result[0].src1_tag = read_tags[1];
		next_result[0].new_tag  = new_tags[0];
		next_result[0].old_tag  = has_dest[0] ? old_tags[0] : '0;
		next_result[0].dest     = rename_group[0].dest;
		next_result[0].kind     = rename_group[0].kind;

		next_result[1].src0_tag = src0_hit ? new_tags[0] : read_tags[2];
		next_result[1].src1_tag = src1_hit ? new_tags[0] : read_tags[3];
		next_result[1].new_tag  = new_tags[1];
		if (!has_dest[1]) begin
			next_result[1].old_tag = '0;
		end else if (dest_hit) begin
			next_result[1].old_tag = new_tags[0];
		end else begin
			next_result[1].old_tag = old_tags[1];
		end
		next_result[1].dest     = rename_group[1].dest;
		next_result[1].kind     = rename_group[1].kind;
	end

	// Map writes land at the same edge as the allocation.
	always_comb begin
		for (int s = 0; s < slot_count; s++) begin
			spec_writes[s].enable = fire && has_dest[s];
			spec_writes[s].arch   = rename_group[s].dest;
			spec_writes[s].tag    = new_tags[s];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= fire;
		end
	end

	// The payload only changes when a group is accepted.
	always_ff @(posedge clock) begin
		if (fire) begin
			rename_result <= next_result;
		end
	end

endmodule

// File: design/retire_stage.sv
/*
 * Retire register stage: holds retires and recover for one cycle, then
 * drives free-list releases, architectural-map writes and recovery.
 */

`timescale 1ns/1ns

module retire_stage (
	input  logic                       clock,
	input  logic                       reset,
	input  pipe_pkg::retire_group      retire_group,
	input  logic                       recover,
	output logic                       flush_pending,
	output logic [1:0]                 release_count,
	output rename_pkg::phys_tag [1:0]  release_tags,
	output rename_pkg::map_write [1:0] arch_writes,
	output logic                       recover_apply
);

	import pipe_pkg::*;

	logic                       recover_q;
	logic [1:0]                 count_q;
	pipe_pkg::retire_entry [1:0] slots_q;
	logic [1:0]                 frees;

	always_ff @(posedge clock) begin
		if (reset) begin
			count_q <= 2'd0;
			recover_q <= 1'b0;
		end else begin
			count_q <= retire_group.count;
			recover_q <= recover;
		end
	end

	// Retire payloads are qualified by count_q.
	always_ff @(posedge clock) begin
		slots_q <= retire_group.slots;
	end

	// A slot frees a tag when it is valid and had a destination.
	always_comb begin
		for (int s = 0; s < 2; s++) begin
			frees[s] = (2'(s) < count_q) && (slots_q[s].kind == dest_reg);
			arch_writes[s].enable = frees[s];
			arch_writes[s].arch   = slots_q[s].dest;
			arch_writes[s].tag    = slots_q[s].new_tag;
		end
	end

	// Old tags are packed toward port 0 for the free list.
	assign release_count = {1'b0, frees[0]} + {1'b0, frees[1]};
	assign release_tags[0] = frees[0] ? slots_q[0].old_tag : slots_q[1].old_tag;
	assign release_tags[1] = slots_q[1].old_tag;

	// The recover held here blocks rename now and is applied at the next edge.
	assign flush_pending = recover_q;
	assign recover_apply = recover_q;

endmodule

// File: design/rename_top.sv
/*
 * Rename subsystem top level.
 * Connects the rename stage, retire stage, free list and map table.
 */

`timescale 1ns/1ns

module rename_top #(
	parameter int phys_count = 96
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   rename_valid,
	input  pipe_pkg::rename_group  rename_group,
	output logic                   rename_ready,
	input  pipe_pkg::retire_group  retire_group,
	input  logic                   recover,
	output logic                   result_valid,
	output pipe_pkg::rename_result rename_result
);

	import rename_pkg::*;

	// Free list to rename stage.
	logic [6:0]    available;
	phys_tag [1:0] alloc_tags;
	logic [1:0]    alloc_count;

	// Rename stage to map table.
	arch_reg [3:0]  read_regs;
	phys_tag [3:0]  read_tags;
	arch_reg [1:0]  dest_regs;
	phys_tag [1:0]  old_tags;
	map_write [1:0] spec_writes;

	// Retire stage to free list and map table.
	logic           flush_pending;
	logic           recover_apply;
	logic [1:0]     release_count;
	phys_tag [1:0]  release_tags;
	map_write [1:0] arch_writes;

	rename_stage rename_stage_i (
		.clock(clock),
		.reset(reset),
		.rename_valid(rename_valid),
		.rename_group(rename_group),
		.rename_ready(rename_ready),
		.flush_pending(flush_pending),
		.available(available),
		.alloc_tags(alloc_tags),
		.alloc_count(alloc_count),
		.read_regs(read_regs),
		.read_tags(read_tags),
		.dest_regs(dest_regs),
		.old_tags(old_tags),
		.spec_writes(spec_writes),
		.result_valid(result_valid),
		.rename_result(rename_result)
	);

	retire_stage retire_stage_i (
		.clock(clock),
		.reset(reset),
		.retire_group(retire_group),
		.recover(recover),
		.flush_pending(flush_pending),
		.release_count(release_count),
		.release_tags(release_tags),
		.arch_writes(arch_writes),
		.recover_apply(recover_apply)
	);

	free_list #(
		.phys_count(phys_count)
	) free_list_i (
		.clock(clock),
		.reset(reset),
		.alloc_count(alloc_count),
		.alloc_tags(alloc_tags),
		.release_count(release_count),
		.release_tags(release_tags),
		.recover(recover_apply),
		.available(available)
	);

	map_table map_table_i (
		.clock(clock),
		.reset(reset),
		.read_regs(read_regs),
		.read_tags(read_tags),
		.dest_regs(dest_regs),
		.old_tags(old_tags),
		.spec_writes(spec_writes),
		.arch_writes(arch_writes),
		.recover(recover_apply)
	);

endmodule

// File: verification/rename_chk.sv
/*
 * Concurrent assertions on the free-list available count and allocation,
 * and the bind that attaches them to every free_list instance.
 */

`timescale 1ns/1ns

module rename_chk #(
	parameter int depth = 64
) (
	input logic       clock,
	input logic       reset,
	input logic [1:0] alloc_count,
	input logic       recover,
	input logic [6:0] available
);

	// Number of assertion failures seen so far.
	int failures = 0;

	// The list can never hold more tags than it has entries.
	count_in_range: assert property (@(posedge clock) disable iff (reset)
		available <= 7'(depth))
		else begin
			failures++;
			$error("Free-list available count %0d is above %0d.", available, depth);
		end

	// Rename may only take tags that are really free.
	alloc_in_range: assert property (@(posedge clock) disable iff (reset)
		7'(alloc_count) <= available)
		else begin
			failures++;
			$error("Allocation of %0d tags with only %0d free.", alloc_count, available);
		end

	// Reset fills the whole ring.
	full_after_reset: assert property (@(posedge clock) reset |=> available == 7'(depth))
		else begin
			failures++;
			$error("Free list is not full in the cycle after reset.");
		end

	// A full flush hands every tag that has not retired back.
	full_after_recover: assert property (@(posedge clock) disable iff (reset)
		recover |=> available == 7'(depth))
		else begin
			failures++;
			$error("Free list is not full in the cycle after recover.");
		end

endmodule

bind free_list rename_chk #(
	.depth(phys_count - rename_pkg::arch_count)
) rename_chk_i (
	.clock(clock),
	.reset(reset),
	.alloc_count(alloc_count),
	.recover(recover),
	.available(available)
);

// File: verification/rename_tb.sv
/*
 * Testbench for the rename subsystem: clock, reset, random stimulus,
 * a reorder-buffer and rename model, compare tasks and a timeout.
 */

`timescale 1ns/1ns

module rename_tb;

	import rename_pkg::*;
	import pipe_pkg::*;

	localparam int phys_count = 96;
	localparam int reset_cycles = 5;
	localparam int random_cycles = 2000;
	// A quarter more than the run needs, which covers reset and the tail.
	localparam int cycle_limit = random_cycles + random_cycles / 4;

	logic         clock;
	logic         reset;
	logic         rename_valid;
	rename_group  group_in;
	logic         rename_ready;
	retire_group  retire_in;
	logic         recover;
	logic         result_valid;
	rename_result result_out;

	// The maps and the free queue mirror the DUT after the last rising edge.
	phys_tag      spec_map [arch_count];
	phys_tag      arch_map [arch_count];
	phys_tag      free_q [$];
	retire_entry  rob_q [$];
	// Retires and recover driven now are applied one edge after they are sampled.
	retire_entry  pend_retire [$];
	logic         pend_recover;
	phys_tag      pend_flushed [$];
	rename_result exp_result;
	logic         exp_valid;
	logic         exp_ready;
	logic         holding;
	integer       seed;
	int           cycle_count = 0;

	rename_top #(
		.phys_count(phys_count)
	) rename_top_i (
		.clock(clock),
		.reset(reset),
		.rename_valid(rename_valid),
		.rename_group(group_in),
		.rename_ready(rename_ready),
		.retire_group(retire_in),
		.recover(recover),
		.result_valid(result_valid),
		.rename_result(result_out)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run went past %0d clock cycles.", cycle_limit);
			$display("RESULT: FAIL");
			$fatal(1, "Timeout.");
		end
	end

	task automatic check_ready(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "Mismatch on %s.", name);
		end
	endtask

	task automatic check_result(input rename_result actual, input rename_result expected);
		if (actual !== expected) begin
			$display("FAILED rename_result: got %h, expected %h", actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "Mismatch on rename_result.");
		end
	endtask

	// Half the groups draw from r0 to r5 only, so registers often collide.
	function automatic arch_reg pick_reg(input logic narrow);
		int value;
		value = $unsigned($random(seed)) % (narrow ? 6 : arch_count);
		return arch_reg'(value);
	endfunction

	task automatic random_group();
		logic narrow;
		narrow = $random(seed) % 2 != 0;
		for (int s = 0; s < slot_count; s++) begin
			group_in[s].src0 = pick_reg(narrow);
			group_in[s].src1 = pick_reg(narrow);
			group_in[s].dest = pick_reg(narrow);
			group_in[s].kind = ($random(seed) % 4 != 0) ? dest_reg : dest_none;
		end
	endtask

	// Identity maps and the free tags in ascending order.
	task automatic reset_model();
		for (int r = 0; r < arch_count; r++) begin
			spec_map[r] = phys_tag'(r);
			arch_map[r] = phys_tag'(r);
		end
		free_q.delete();
		for (int t = arch_count; t < phys_count; t++) begin
			free_q.push_back(phys_tag'(t));
		end
		rob_q.delete();
		pend_retire.delete();
		pend_flushed.delete();
		pend_recover = 1'b0;
	endtask

	// Slots are renamed one after the other, so slot 1 sees slot 0's write.
	task automatic rename_model(input rename_group group);
		rename_out   out;
		retire_entry entry;
		for (int s = 0; s < slot_count; s++) begin
			out.src0_tag = spec_map[group[s].src0];
			out.src1_tag = spec_map[group[s].src1];
			out.dest = group[s].dest;
			out.kind = group[s].kind;
			out.new_tag = '0;
			out.old_tag = '0;
			if (group[s].kind == dest_reg) begin
				out.new_tag = free_q.pop_front();
				out.old_tag = spec_map[group[s].dest];
				spec_map[group[s].dest] = out.new_tag;
			end
			exp_result[s] = out;
			entry.dest = out.dest;
			entry.new_tag = out.new_tag;
			entry.old_tag = out.old_tag;
			entry.kind = out.kind;
			rob_q.push_back(entry);
		end
	endtask

	// Retires land first, then a recover rebuilds the speculative state.
	// Tags of discarded instructions come back ahead of the free ones.
	task automatic retire_model();
		foreach (pend_retire[i]) begin
			if (pend_retire[i].kind == dest_reg) begin
				free_q.push_back(pend_retire[i].old_tag);
				arch_map[pend_retire[i].dest] = pend_retire[i].new_tag;
			end
		end
		if (pend_recover) begin
			spec_map = arch_map;
			free_q = {pend_flushed, free_q};
		end
	endtask

	task automatic compare_outputs();
		if (rename_top_i.free_list_i.rename_chk_i.failures != 0) begin
			$display("An assertion on the free list failed.");
			$display("RESULT: FAIL");
			$fatal(1, "Assertion failure.");
		end
		check_ready("rename_ready", rename_ready, exp_ready);
		check_ready("result_valid", result_valid, exp_valid);
		if (exp_valid) begin
			check_result(result_out, exp_result);
		end
	endtask

	task automatic drive_cycle();
		int   count;
		logic fire;
		retire_model();
		// Up to two of the oldest renamed instructions retire, in order.
		count = $unsigned($random(seed)) % 3;
		if (count > rob_q.size()) begin
			count = rob_q.size();
		end
		pend_retire.delete();
		for (int s = 0; s < slot_count; s++) begin
			retire_in.slots[s] = retire_entry'(20'($random(seed)));
			if (s < count) begin
				retire_in.slots[s] = rob_q.pop_front();
				pend_retire.push_back(retire_in.slots[s]);
			end
		end
		retire_in.count = 2'(count);
		// A refused group stays on the inputs until it is taken.
		if (!holding) begin
			rename_valid = $random(seed) % 8 != 0;
			random_group();
		end
		fire = rename_valid && exp_ready;
		holding = rename_valid && !fire;
		exp_valid = fire;
		if (fire) begin
			rename_model(group_in);
		end
		// A recover discards every instruction still in the buffer.
		recover = $unsigned($random(seed)) % 100 < 3;
		pend_recover = recover;
		pend_flushed.delete();
		if (recover) begin
			foreach (rob_q[i]) begin
				if (rob_q[i].kind == dest_reg) begin
					pend_flushed.push_back(rob_q[i].new_tag);
				end
			end
			rob_q.delete();
		end
	endtask

	initial begin
		seed = 32'hac7a;
		reset = 1'b1;
		rename_valid = 1'b0;
		group_in = '0;
		retire_in = '0;
		recover = 1'b0;
		holding = 1'b0;
		exp_valid = 1'b0;
		reset_model();
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int cycle = 0; cycle < random_cycles; cycle++) begin
			exp_ready = (free_q.size() >= 2) && !pend_recover;
			compare_outputs();
			drive_cycle();
			@(negedge clock);
		end
		exp_ready = (free_q.size() >= 2) && !pend_recover;
		compare_outputs();
		if (rename_top_i.free_list_i.rename_chk_i.failures != 0) begin
			$display("RESULT: FAIL");
		end else begin
			$display("RESULT: PASS");
		end
		$finish;
	end

endmodule

// File: sources.f
design/rename_pkg.sv
design/pipe_pkg.sv
design/free_list.sv
design/map_table.sv
design/rename_stage.sv
design/retire_stage.sv
design/rename_top.sv
verification/rename_chk.sv
verification/rename_tb.sv
